// File: filelist.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/pipe_reg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/proc.sv
testbench/proc_checker.sv
testbench/proc_assertions.sv
testbench/proc_tb.sv

// File: rtl/decode.sv
module decode
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic            clk,
   input  logic            reset_i,
   input  logic            valid_i,
   input  if_id_t          if_id_i,
   input  id_ex_t          ex_dst_i,
   input  logic            ex_valid_i,
   input  ex_mem_t         mem_dst_i,
   input  logic            mem_valid_i,
   input  rf_write_t       rf_write_i,
   output id_ex_t          id_ex_o,
   output logic            valid_o,
   output logic            stall_o,
   output logic            flush_o,
   output logic            redirect_o,
   output logic [PC_W-1:0] target_o,
   output logic            err_o
);

   logic [XLEN-1:0]  rf [NREG];
   opcode_e          opc;
   logic [REG_W-1:0] rd;
   logic [REG_W-1:0] rs;
   logic [REG_W-1:0] rt;
   logic [XLEN-1:0]  rd_val;
   logic [XLEN-1:0]  rs_val;
   logic [XLEN-1:0]  rt_val;
   logic             use_rd;
   logic             use_rs;
   logic             use_rt;
   logic             illegal;
   logic             ex_hit;
   logic             mem_hit;
   logic             go;
   logic             taken;
   logic             halted_q;
   logic             err_q;
   logic [PC_W-1:0]  br_off;

   assign opc = opcode_e'(if_id_i.instr[OPC_HI:OPC_LO]);
   assign rd  = if_id_i.instr[RD_LO +: REG_W];
   assign rs  = if_id_i.instr[RS_LO +: REG_W];
   assign rt  = if_id_i.instr[RT_LO +: REG_W];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < NREG; i++) begin
            rf[i] <= '0;
         end
      end else if (rf_write_i.en) begin
         rf[rf_write_i.addr] <= rf_write_i.data;
      end
   end

   // Write-back value bypassed to same-cycle reads
   assign rd_val = (rf_write_i.en && rf_write_i.addr == rd) ? rf_write_i.data : rf[rd];
   assign rs_val = (rf_write_i.en && rf_write_i.addr == rs) ? rf_write_i.data : rf[rs];
   assign rt_val = (rf_write_i.en && rf_write_i.addr == rt) ? rf_write_i.data : rf[rt];

   always_comb begin
      id_ex_o         = '0;
      id_ex_o.alu_op  = ALU_ADD;
      id_ex_o.rs_val  = rs_val;
      id_ex_o.op_b    = rt_val;
      id_ex_o.imm     = XLEN'(signed'(if_id_i.instr[IMM6_W-1:0]));
      id_ex_o.rd      = rd;
      use_rd          = 1'b0;
      use_rs          = 1'b0;
      use_rt          = 1'b0;
      illegal         = 1'b0;
      case (opc)
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            id_ex_o.reg_write = 1'b1;
            use_rs            = 1'b1;
            use_rt            = 1'b1;
            case (opc)
               OP_SUB:  id_ex_o.alu_op = ALU_SUB;
               OP_AND:  id_ex_o.alu_op = ALU_AND;
               OP_XOR:  id_ex_o.alu_op = ALU_XOR;
               default: id_ex_o.alu_op = ALU_ADD;
            endcase
         end
         OP_ADDI, OP_LD: begin
            id_ex_o.use_imm   = 1'b1;
            id_ex_o.reg_write = 1'b1;
            id_ex_o.mem_read  = (opc == OP_LD);
            use_rs            = 1'b1;
         end
         OP_ST: begin
            id_ex_o.use_imm   = 1'b1;
            id_ex_o.mem_write = 1'b1;
            id_ex_o.op_b      = rd_val;
            use_rs            = 1'b1;
            use_rd            = 1'b1;
         end
         OP_BEQZ, OP_BNEZ: use_rd = 1'b1;
         OP_HALT:          id_ex_o.halt = 1'b1;
         OP_J, OP_NOP: ;
         // Retires as a NOP
         default:          illegal = 1'b1;
      endcase
   end

   // RAW check against instructions not yet in the register file
   assign ex_hit = ex_valid_i && ex_dst_i.reg_write &&
                   ((use_rs && ex_dst_i.rd == rs) || (use_rt && ex_dst_i.rd == rt) ||
                    (use_rd && ex_dst_i.rd == rd));
   assign mem_hit = mem_valid_i && mem_dst_i.reg_write &&
                    ((use_rs && mem_dst_i.rd == rs) || (use_rt && mem_dst_i.rd == rt) ||
                     (use_rd && mem_dst_i.rd == rd));

   // After HALT the front end stays frozen
   assign stall_o = (valid_i && (ex_hit || mem_hit)) || halted_q;
   assign go      = valid_i && !stall_o;
   assign valid_o = go;

   assign taken = go && ((opc == OP_BEQZ && rd_val == '0) ||
                         (opc == OP_BNEZ && rd_val != '0) || opc == OP_J);

   assign br_off = (opc == OP_J) ? PC_W'(signed'(if_id_i.instr[IMM12_W-1:0]))
                                 : PC_W'(signed'(if_id_i.instr[IMM9_W-1:0]));

   assign target_o   = if_id_i.pc_inc + br_off;
   assign redirect_o = taken;
   assign flush_o    = taken || (go && opc == OP_HALT);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         halted_q <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         if (go && opc == OP_HALT) begin
            halted_q <= 1'b1;
         end
         if (go && illegal) begin
            err_q <= 1'b1;
         end
      end
   end

   assign err_o = err_q;

endmodule

// File: rtl/execute.sv
module execute
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  id_ex_t  id_ex_i,
   output ex_mem_t ex_mem_o
);

   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_out;

   assign op_a = id_ex_i.rs_val;
   assign op_b = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.op_b;

   // Also forms load and store addresses as base plus offset
   always_comb begin
      case (id_ex_i.alu_op)
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_XOR: alu_out = op_a ^ op_b;
         default: alu_out = op_a + op_b;
      endcase
   end

   assign ex_mem_o.result    = alu_out;
   assign ex_mem_o.st_val    = id_ex_i.op_b;
   assign ex_mem_o.rd        = id_ex_i.rd;
   assign ex_mem_o.reg_write = id_ex_i.reg_write;
   assign ex_mem_o.mem_read  = id_ex_i.mem_read;
   assign ex_mem_o.mem_write = id_ex_i.mem_write;
   assign ex_mem_o.halt      = id_ex_i.halt;

endmodule

// File: rtl/fetch.sv
module fetch
   import isa_pkg::*;
   import pipe_pkg::*;
#(
   parameter int  IMEM_DEPTH = 256,
   localparam int AW         = $clog2(IMEM_DEPTH)
) (
   input  logic            clk,
   input  logic            reset_i,
   input  logic            imem_we_i,
   input  logic [AW-1:0]   imem_addr_i,
   input  logic [XLEN-1:0] imem_data_i,
   input  logic            stall_i,
   input  logic            redirect_i,
   input  logic [PC_W-1:0] target_i,
   output if_id_t          if_id_o,
   output logic            valid_o
);

   logic [XLEN-1:0] imem [IMEM_DEPTH];
   logic [AW-1:0]   pc_q;

   // Program load only while the core is held in reset
   always_ff @(posedge clk) begin
      if (reset_i && imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         pc_q <= '0;
      end else if (redirect_i) begin
         pc_q <= target_i[AW-1:0];
      end else if (!stall_i) begin
         pc_q <= pc_q + 1'b1;
      end
   end

   assign if_id_o.instr  = imem[pc_q];
   assign if_id_o.pc_inc = PC_W'(pc_q) + PC_W'(1);

   // Nothing is fetched while the program is loaded
   assign valid_o = !reset_i;

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

   // Machine word and register file
   localparam int XLEN  = 16;
   localparam int NREG  = 8;
   localparam int REG_W = $clog2(NREG);

   // Instruction fields
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 12;
   localparam int RD_LO  = 9;
   localparam int RS_LO  = 6;
   localparam int RT_LO  = 3;

   // Immediate widths, all sign-extended
   localparam int IMM6_W  = 6;
   localparam int IMM9_W  = 9;
   localparam int IMM12_W = 12;

   // Program address as carried down the pipe, wide enough for a jump offset
   localparam int PC_W = IMM12_W;

   // Codes 4'hC to 4'hF are illegal
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_XOR  = 4'h4,
      OP_ADDI = 4'h5,
      OP_LD   = 4'h6,
      OP_ST   = 4'h7,
      OP_BEQZ = 4'h8,
      OP_BNEZ = 4'h9,
      OP_J    = 4'hA,
      OP_HALT = 4'hB
   } opcode_e;

   // Loads and stores use ALU_ADD for the address
   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_e;

endpackage

// File: rtl/memory.sv
module memory
   import isa_pkg::*;
   import pipe_pkg::*;
#(
   parameter int  DMEM_DEPTH = 256,
   localparam int AW         = $clog2(DMEM_DEPTH)
) (
   input  logic    clk,
   input  logic    reset_i,
   input  logic    valid_i,
   input  ex_mem_t ex_mem_i,
   output mem_wb_t mem_wb_o
);

   logic [XLEN-1:0] dmem [DMEM_DEPTH];
   logic [AW-1:0]   addr;
   logic            halt_q;

   assign addr = ex_mem_i.result[AW-1:0];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (valid_i && ex_mem_i.mem_write) begin
         dmem[addr] <= ex_mem_i.st_val;
      end
   end

   // Halt is remembered so the flag survives the bubbles behind it
   always_ff @(posedge clk) begin
      if (reset_i) begin
         halt_q <= 1'b0;
      end else if (valid_i && ex_mem_i.halt) begin
         halt_q <= 1'b1;
      end
   end

   // Write-back select
   assign mem_wb_o.result    = ex_mem_i.mem_read ? dmem[addr] : ex_mem_i.result;
   assign mem_wb_o.rd        = ex_mem_i.rd;
   assign mem_wb_o.reg_write = ex_mem_i.reg_write;
   assign mem_wb_o.halt      = (valid_i && ex_mem_i.halt) || halt_q;

endmodule

// File: rtl/pipe_pkg.sv
package pipe_pkg;
   import isa_pkg::*;

   // Fetched word and address of the next one
   typedef struct packed {
      logic [XLEN-1:0] instr;
      logic [PC_W-1:0] pc_inc;
   } if_id_t;

   typedef struct packed {
      alu_op_e          alu_op;
      logic             use_imm;
      logic [XLEN-1:0]  rs_val;
      logic [XLEN-1:0]  op_b;      // rt for ALU ops, rd for stores
      logic [XLEN-1:0]  imm;
      logic [REG_W-1:0] rd;
      logic             reg_write;
      logic             mem_read;
      logic             mem_write;
      logic             halt;
   } id_ex_t;

   typedef struct packed {
      logic [XLEN-1:0]  result;
      logic [XLEN-1:0]  st_val;
      logic [REG_W-1:0] rd;
      logic             reg_write;
      logic             mem_read;
      logic             mem_write;
      logic             halt;
   } ex_mem_t;

   // Result is final here, write-back only steers it
   typedef struct packed {
      logic [XLEN-1:0]  result;
      logic [REG_W-1:0] rd;
      logic             reg_write;
      logic             halt;
   } mem_wb_t;

   typedef struct packed {
      logic             en;
      logic [REG_W-1:0] addr;
      logic [XLEN-1:0]  data;
   } rf_write_t;

endpackage

// File: rtl/pipe_reg.sv
module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset_i,
   input  logic     stall_i,
   input  logic     flush_i,
   input  logic     valid_i,
   input  payload_t data_i,
   output logic     valid_o,
   output payload_t data_o
);

   // Flush wins over stall
   always_ff @(posedge clk) begin
      if (reset_i || flush_i) begin
         valid_o <= 1'b0;
      end else if (!stall_i) begin
         valid_o <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_i) begin
         data_o <= data_i;
      end
   end

endmodule

// File: rtl/proc.sv
module proc
   import isa_pkg::*;
   import pipe_pkg::*;
#(
   parameter int  IMEM_DEPTH = 256,
   parameter int  DMEM_DEPTH = 256,
   localparam int IAW        = $clog2(IMEM_DEPTH)
) (
   input  logic             clk,
   input  logic             reset_i,
   input  logic             imem_we_i,
   input  logic [IAW-1:0]   imem_addr_i,
   input  logic [XLEN-1:0]  imem_data_i,
   output logic             wb_valid_o,
   output logic [REG_W-1:0] wb_reg_o,
   output logic [XLEN-1:0]  wb_data_o,
   output logic             halt_o,
   output logic             err_o
);

   // Stage outputs before their registers
   if_id_t    if_id_d;
   id_ex_t    id_ex_d;
   ex_mem_t   ex_mem_d;
   mem_wb_t   mem_wb_d;
   logic      if_valid;
   logic      id_valid;

   // Register outputs
   if_id_t    if_id_q;
   id_ex_t    id_ex_q;
   ex_mem_t   ex_mem_q;
   mem_wb_t   mem_wb_q;
   logic      if_id_valid;
   logic      id_ex_valid;
   logic      ex_mem_valid;
   logic      mem_wb_valid;

   logic            stall;
   logic            flush;
   logic            redirect;
   logic [PC_W-1:0] target;
   rf_write_t       rf_wr;

   fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
      .clk(clk), .reset_i(reset_i), .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i),
      .imem_data_i(imem_data_i), .stall_i(stall), .redirect_i(redirect), .target_i(target),
      .if_id_o(if_id_d), .valid_o(if_valid)
   );

   pipe_reg #(.payload_t(if_id_t)) if_id_reg (
      .clk(clk), .reset_i(reset_i), .stall_i(stall), .flush_i(flush),
      .valid_i(if_valid), .data_i(if_id_d), .valid_o(if_id_valid), .data_o(if_id_q)
   );

   decode decode_i (
      .clk(clk), .reset_i(reset_i), .valid_i(if_id_valid), .if_id_i(if_id_q),
      .ex_dst_i(id_ex_q), .ex_valid_i(id_ex_valid), .mem_dst_i(ex_mem_q),
      .mem_valid_i(ex_mem_valid), .rf_write_i(rf_wr), .id_ex_o(id_ex_d), .valid_o(id_valid),
      .stall_o(stall), .flush_o(flush), .redirect_o(redirect), .target_o(target), .err_o(err_o)
   );

   // Bubbles come from decode, so later registers never stall
   pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
      .clk(clk), .reset_i(reset_i), .stall_i(1'b0), .flush_i(1'b0),
      .valid_i(id_valid), .data_i(id_ex_d), .valid_o(id_ex_valid), .data_o(id_ex_q)
   );

   execute execute_i (
      .id_ex_i(id_ex_q), .ex_mem_o(ex_mem_d)
   );

   pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
      .clk(clk), .reset_i(reset_i), .stall_i(1'b0), .flush_i(1'b0),
      .valid_i(id_ex_valid), .data_i(ex_mem_d), .valid_o(ex_mem_valid), .data_o(ex_mem_q)
   );

   memory #(.DMEM_DEPTH(DMEM_DEPTH)) memory_i (
      .clk(clk), .reset_i(reset_i), .valid_i(ex_mem_valid), .ex_mem_i(ex_mem_q),
      .mem_wb_o(mem_wb_d)
   );

   pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
      .clk(clk), .reset_i(reset_i), .stall_i(1'b0), .flush_i(1'b0),
      .valid_i(ex_mem_valid), .data_i(mem_wb_d), .valid_o(mem_wb_valid), .data_o(mem_wb_q)
   );

   // Write-back to the register file
   assign rf_wr.en   = mem_wb_valid && mem_wb_q.reg_write;
   assign rf_wr.addr = mem_wb_q.rd;
   assign rf_wr.data = mem_wb_q.result;

   assign wb_valid_o = rf_wr.en;
   assign wb_reg_o   = mem_wb_q.rd;
   assign wb_data_o  = mem_wb_q.result;
   assign halt_o     = mem_wb_q.halt;

endmodule

// File: testbench/proc_assertions.sv
module proc_assertions (
   input logic clk,
   input logic reset_i,
   input logic wb_valid_i,
   input logic halt_i,
   input logic err_i
);

   int failures = 0;

   // Reset of two cycles or more leaves every output low
   reset_clears: assert property (@(posedge clk)
      $fell(reset_i) |-> !wb_valid_i && !halt_i && !err_i)
      else begin
         failures++;
         $error("outputs active after reset");
      end

   halt_sticky: assert property (@(posedge clk) disable iff (reset_i) halt_i |=> halt_i)
      else begin
         failures++;
         $error("halt_o fell without reset");
      end

   err_sticky: assert property (@(posedge clk) disable iff (reset_i) err_i |=> err_i)
      else begin
         failures++;
         $error("err_o fell without reset");
      end

   quiet_after_halt: assert property (@(posedge clk) disable iff (reset_i)
      halt_i |-> !wb_valid_i)
      else begin
         failures++;
         $error("register write retired after halt");
      end

endmodule

bind proc proc_assertions assertions_i (
   .clk(clk), .reset_i(reset_i), .wb_valid_i(wb_valid_o), .halt_i(halt_o), .err_i(err_o)
);

// File: testbench/proc_checker.sv
module proc_checker
   import isa_pkg::*;
(
   input logic             clk,
   input logic             reset_i,
   input logic             wb_valid_i,
   input logic [REG_W-1:0] wb_reg_i,
   input logic [XLEN-1:0]  wb_data_i,
   input logic             halt_i,
   input logic             err_i
);

   typedef struct packed {
      logic [REG_W-1:0] rd;
      logic [XLEN-1:0]  data;
   } reg_write_t;

   reg_write_t exp_q [$];
   int         error_count = 0;
   int         retired     = 0;
   int         expected    = 0;
   logic       halt_seen   = 1'b0;

   task automatic clear_expected();
      exp_q.delete();
      retired  = 0;
      expected = 0;
   endtask

   task automatic expect_write(input logic [REG_W-1:0] rd, input logic [XLEN-1:0] data);
      reg_write_t w;
      w.rd   = rd;
      w.data = data;
      exp_q.push_back(w);
      expected++;
   endtask

   // Outputs change after the rising edge, so compare at the falling one
   always @(negedge clk) begin : compare
      reg_write_t w;
      if (reset_i !== 1'b0) begin
         halt_seen = 1'b0;
      end else begin
         if (wb_valid_i === 1'b1) begin
            if (halt_seen) begin
               error_count++;
               $display("** Error at %0t: write to r%0d retired after halt", $time, wb_reg_i);
            end else if (exp_q.size() == 0) begin
               error_count++;
               $display("** Error at %0t: unexpected write r%0d = %h",
                        $time, wb_reg_i, wb_data_i);
            end else begin
               w = exp_q.pop_front();
               retired++;
               if (wb_reg_i !== w.rd || wb_data_i !== w.data) begin
                  error_count++;
                  $display("** Error at %0t: write %0d is r%0d = %h, expected r%0d = %h",
                           $time, retired, wb_reg_i, wb_data_i, w.rd, w.data);
               end
            end
         end
         if (halt_seen && halt_i !== 1'b1) begin
            error_count++;
            $display("** Error at %0t: halt_o fell without reset", $time);
         end
         if (halt_i === 1'b1) begin
            halt_seen = 1'b1;
         end
      end
   end

   task automatic check_end(input logic err_exp);
      if (exp_q.size() != 0) begin
         error_count++;
         $display("** Error at %0t: only %0d of %0d expected writes retired",
                  $time, retired, expected);
      end
      if (halt_i !== 1'b1) begin
         error_count++;
         $display("** Error at %0t: halt_o is low at the end of the run", $time);
      end
      if (err_i !== err_exp) begin
         error_count++;
         $display("** Error at %0t: err_o is %b, expected %b", $time, err_i, err_exp);
      end
   endtask

endmodule

// File: testbench/proc_tb.sv
module proc_tb
   import isa_pkg::*;
();

   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;
   localparam int IAW        = $clog2(IMEM_DEPTH);
   localparam int TIMEOUT    = 2000;
   // Cycles watched after halt for stray writes
   localparam int DRAIN      = 8;

   // One program word and the write it should retire
   typedef struct packed {
      logic [XLEN-1:0]  instr;
      logic             wr;
      logic [REG_W-1:0] rd;
      logic [XLEN-1:0]  data;
   } row_t;

   logic             clk = 1'b0;
   logic             reset_i;
   logic             imem_we_i;
   logic [IAW-1:0]   imem_addr_i;
   logic [XLEN-1:0]  imem_data_i;
   logic             wb_valid_o;
   logic [REG_W-1:0] wb_reg_o;
   logic [XLEN-1:0]  wb_data_o;
   logic             halt_o;
   logic             err_o;

   row_t prog [$];
   int   timeouts;

   proc #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) proc_i (
      .clk(clk), .reset_i(reset_i), .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i),
      .imem_data_i(imem_data_i), .wb_valid_o(wb_valid_o), .wb_reg_o(wb_reg_o),
      .wb_data_o(wb_data_o), .halt_o(halt_o), .err_o(err_o)
   );

   proc_checker checker_i (
      .clk(clk), .reset_i(reset_i), .wb_valid_i(wb_valid_o), .wb_reg_i(wb_reg_o),
      .wb_data_i(wb_data_o), .halt_i(halt_o), .err_i(err_o)
   );

   always #5 clk = ~clk;

   function automatic logic [XLEN-1:0] r_type(input opcode_e op, input logic [REG_W-1:0] rd,
                                              input logic [REG_W-1:0] rs,
                                              input logic [REG_W-1:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [XLEN-1:0] i_type(input opcode_e op, input logic [REG_W-1:0] rd,
                                              input logic [REG_W-1:0] rs, input int imm);
      return {op, rd, rs, imm[IMM6_W-1:0]};
   endfunction

   // Register tested sits in the rd field
   function automatic logic [XLEN-1:0] branch_word(input opcode_e op,
                                                   input logic [REG_W-1:0] r, input int off);
      return {op, r, off[IMM9_W-1:0]};
   endfunction

   function automatic logic [XLEN-1:0] jump_word(input int off);
      return {OP_J, off[IMM12_W-1:0]};
   endfunction

   task automatic append_row(input logic [XLEN-1:0] instr, input logic wr,
                             input logic [REG_W-1:0] rd, input logic [XLEN-1:0] data);
      row_t row;
      row.instr = instr;
      row.wr    = wr;
      row.rd    = rd;
      row.data  = data;
      prog.push_back(row);
   endtask

   task automatic basic_program();
      prog.delete();
      // Independent ALU operations
      append_row(i_type(OP_ADDI, 3'd1, 3'd0, 5), 1'b1, 3'd1, 16'h0005);
      append_row(i_type(OP_ADDI, 3'd2, 3'd0, -3), 1'b1, 3'd2, 16'hFFFD);
      append_row(i_type(OP_ADDI, 3'd3, 3'd0, 12), 1'b1, 3'd3, 16'h000C);
      append_row(r_type(OP_ADD, 3'd4, 3'd1, 3'd3), 1'b1, 3'd4, 16'h0011);
      append_row(r_type(OP_SUB, 3'd5, 3'd1, 3'd2), 1'b1, 3'd5, 16'h0008);
      append_row(r_type(OP_AND, 3'd6, 3'd3, 3'd2), 1'b1, 3'd6, 16'h000C);
      append_row(r_type(OP_XOR, 3'd7, 3'd1, 3'd3), 1'b1, 3'd7, 16'h0009);
      // Each one waits on the one before
      append_row(i_type(OP_ADDI, 3'd1, 3'd1, 1), 1'b1, 3'd1, 16'h0006);
      append_row(r_type(OP_ADD, 3'd1, 3'd1, 3'd1), 1'b1, 3'd1, 16'h000C);
      append_row(r_type(OP_SUB, 3'd2, 3'd1, 3'd4), 1'b1, 3'd2, 16'hFFFB);
      // Store to word 16, read it back and use it
      append_row(i_type(OP_ST, 3'd2, 3'd3, 4), 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_LD, 3'd5, 3'd3, 4), 1'b1, 3'd5, 16'hFFFB);
      append_row(r_type(OP_ADD, 3'd6, 3'd5, 3'd5), 1'b1, 3'd6, 16'hFFF6);
      // Taken branches, one shadow word each
      append_row(branch_word(OP_BEQZ, 3'd0, 1), 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd7, 3'd0, 31), 1'b0, 3'd0, 16'h0000);
      append_row(branch_word(OP_BNEZ, 3'd1, 1), 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd7, 3'd0, 30), 1'b0, 3'd0, 16'h0000);
      // Untaken ones fall through
      append_row(branch_word(OP_BEQZ, 3'd1, 5), 1'b0, 3'd0, 16'h0000);
      append_row(branch_word(OP_BNEZ, 3'd0, 5), 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd7, 3'd0, 7), 1'b1, 3'd7, 16'h0007);
      append_row(jump_word(2), 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd7, 3'd0, 1), 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd7, 3'd0, 2), 1'b0, 3'd0, 16'h0000);
      append_row(r_type(OP_XOR, 3'd3, 3'd7, 3'd1), 1'b1, 3'd3, 16'h000B);
      append_row({OP_HALT, 12'h000}, 1'b0, 3'd0, 16'h0000);
      // Never executed
      append_row(i_type(OP_ADDI, 3'd1, 3'd0, 9), 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd2, 3'd0, 9), 1'b0, 3'd0, 16'h0000);
   endtask

   task automatic illegal_op_program();
      prog.delete();
      append_row(i_type(OP_ADDI, 3'd1, 3'd0, 3), 1'b1, 3'd1, 16'h0003);
      append_row(16'hC000, 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd2, 3'd1, 4), 1'b1, 3'd2, 16'h0007);
      append_row(r_type(OP_ADD, 3'd3, 3'd2, 3'd1), 1'b1, 3'd3, 16'h000A);
      append_row({OP_HALT, 12'h000}, 1'b0, 3'd0, 16'h0000);
      append_row(i_type(OP_ADDI, 3'd4, 3'd0, 1), 1'b0, 3'd0, 16'h0000);
   endtask

   // Reset, load the table, run until halt and check the end state
   task automatic run_program(input logic err_exp);
      int cycles;
      checker_i.clear_expected();
      @(posedge clk);
      reset_i   <= 1'b1;
      imem_we_i <= 1'b0;
      repeat (2) @(posedge clk);
      foreach (prog[i]) begin
         imem_we_i   <= 1'b1;
         imem_addr_i <= IAW'(i);
         imem_data_i <= prog[i].instr;
         if (prog[i].wr) begin
            checker_i.expect_write(prog[i].rd, prog[i].data);
         end
         @(posedge clk);
      end
      imem_we_i <= 1'b0;
      reset_i   <= 1'b0;
      cycles = 0;
      while (halt_o !== 1'b1 && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (halt_o !== 1'b1) begin
         timeouts++;
         $display("Timeout: the processor never halted within %0d cycles", TIMEOUT);
      end else begin
         repeat (DRAIN) @(negedge clk);
      end
      @(posedge clk);
      checker_i.check_end(err_exp);
   endtask

   initial begin
      reset_i     = 1'b1;
      imem_we_i   = 1'b0;
      imem_addr_i = '0;
      imem_data_i = '0;
      timeouts    = 0;
      basic_program();
      run_program(1'b0);
      illegal_op_program();
      run_program(1'b1);
      $display("Error counts: checker %0d, assertions %0d, timeouts %0d",
               checker_i.error_count, proc_i.assertions_i.failures, timeouts);
      if (checker_i.error_count == 0 && proc_i.assertions_i.failures == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
